//--- bitmap_addr.sv
/* bitmap address stage
   two-stage clip and address calculation for drawn pixels */

`timescale 1ns/1ps
`include "lines_defs.svh"

module bitmap_addr (
    input  logic                 clk_sys,
    input  logic                 rst_sys,
    input  lines_pkg::draw_pix_t pix,
    output logic                 we,
    output lines_pkg::fb_addr_t  addr,
    output lines_pkg::cidx_t     cidx
);

    logic                clip;
    logic                v1, clip1;     // stage one
    lines_pkg::fb_addr_t row1, x1;
    lines_pkg::cidx_t    c1;

    // outside bitmap, dropped rather than wrapped
    assign clip = (pix.x < 0) || (pix.x >= `LINES_FB_WIDTH)
               || (pix.y < 0) || (pix.y >= `LINES_FB_HEIGHT);

    // stage one, clip flag and row product
    always_ff @(posedge clk_sys) begin
        v1    <= pix.valid;
        clip1 <= clip;
        row1  <= lines_pkg::fb_addr_t'(pix.y) * lines_pkg::fb_addr_t'(`LINES_FB_WIDTH);
        x1    <= lines_pkg::fb_addr_t'(pix.x);  // truncation only hits clipped pixels
        c1    <= pix.cidx;
        if (rst_sys) v1 <= 1'b0;
    end

    // stage two, column add and write enable
    always_ff @(posedge clk_sys) begin
        we   <= v1 && !clip1;
        addr <= row1 + x1;
        cidx <= c1;
        if (rst_sys) we <= 1'b0;
    end

endmodule

//--- clut_paint.sv
/* palette and painting
   fixed four-entry palette lookup, black outside active area, registered video out */

`timescale 1ns/1ps
`include "lines_defs.svh"

module clut_paint (
    input  logic               clk_sys,
    input  logic               rst_sys,
    input  lines_pkg::cidx_t   cidx,
    input  lines_pkg::raster_t pos,
    output logic               hsync,
    output logic               vsync,
    output logic               de,
    output lines_pkg::chan_t   red,
    output lines_pkg::chan_t   green,
    output lines_pkg::chan_t   blue
);

    lines_pkg::colr_t colr;
    lines_pkg::colr_t paint;

    always_comb begin
        case (cidx)
            2'd0:    colr = `LINES_PAL_0;
            2'd1:    colr = `LINES_PAL_1;
            2'd2:    colr = `LINES_PAL_2;
            default: colr = `LINES_PAL_3;
        endcase
        paint = pos.de ? colr : '0;  // black in blanking
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            hsync <= pos.hsync;
            vsync <= pos.vsync;
            de    <= pos.de;
            red   <= paint[3*`LINES_CHANW-1 -: `LINES_CHANW];
            green <= paint[2*`LINES_CHANW-1 -: `LINES_CHANW];
            blue  <= paint[`LINES_CHANW-1:0];
        end
    end

endmodule

//--- display_timing.sv
/* display timing
   raster counters with signed position, sync, data enable and line and frame strobes */

`timescale 1ns/1ps
`include "lines_defs.svh"

module display_timing (
    input  logic               clk_sys,
    input  logic               rst_sys,
    output lines_pkg::raster_t pos
);

    lines_pkg::coord_t sx_nxt;
    lines_pkg::coord_t sy_nxt;

    // next position, wraps back to the first blanking pixel
    always_comb begin
        if (pos.sx == lines_pkg::coord_t'(`LINES_H_ACTIVE - 1)) begin
            sx_nxt = lines_pkg::coord_t'(-`LINES_H_BLANK);
            if (pos.sy == lines_pkg::coord_t'(`LINES_V_ACTIVE - 1)) begin
                sy_nxt = lines_pkg::coord_t'(-`LINES_V_BLANK);  // new frame
            end else begin
                sy_nxt = lines_pkg::coord_t'(pos.sy + 1);
            end
        end else begin
            sx_nxt = lines_pkg::coord_t'(pos.sx + 1);
            sy_nxt = pos.sy;
        end
    end

    // flags derived from the next position so all fields stay aligned
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            // park on the last pixel, first edge starts a frame
            pos.sx    <= lines_pkg::coord_t'(`LINES_H_ACTIVE - 1);
            pos.sy    <= lines_pkg::coord_t'(`LINES_V_ACTIVE - 1);
            pos.hsync <= 1'b0;
            pos.vsync <= 1'b0;
            pos.de    <= 1'b0;
            pos.line  <= 1'b0;
            pos.frame <= 1'b0;
        end else begin
            pos.sx    <= sx_nxt;
            pos.sy    <= sy_nxt;
            pos.hsync <= (sx_nxt >= `LINES_H_SYNC_START) && (sx_nxt < `LINES_H_SYNC_END);
            pos.vsync <= (sy_nxt >= `LINES_V_SYNC_START) && (sy_nxt < `LINES_V_SYNC_END);
            pos.de    <= (sx_nxt >= 0) && (sy_nxt >= 0);    // active area
            pos.line  <= (sx_nxt == -`LINES_H_BLANK);
            pos.frame <= (sx_nxt == -`LINES_H_BLANK) && (sy_nxt == -`LINES_V_BLANK);
        end
    end

endmodule

//--- framebuffer_sdp.sv
/* framebuffer memory
   simple dual-port block ram of colour indices with registered read */

`timescale 1ns/1ps
`include "lines_defs.svh"

module framebuffer_sdp (
    input  logic                clk_sys,
    input  logic                we,
    input  lines_pkg::fb_addr_t addr_write,
    input  lines_pkg::cidx_t    data_in,
    input  lines_pkg::fb_addr_t addr_read,
    output lines_pkg::cidx_t    data_out
);

    lines_pkg::cidx_t mem [`LINES_FB_WIDTH*`LINES_FB_HEIGHT];

    // same-address read and write returns old data
    always_ff @(posedge clk_sys) begin
        if (we) mem[addr_write] <= data_in;
        data_out <= mem[addr_read];
    end

endmodule

//--- lines_defs.svh
/* line drawing subsystem defines
   display mode, framebuffer geometry, coordinate widths and the fixed palette */

`ifndef LINES_DEFS_SVH
`define LINES_DEFS_SVH

// small simulation-sized display mode
`define LINES_H_ACTIVE      64      // active pixels per line
`define LINES_H_BLANK       40      // blanking pixels, at least fb width plus 2
`define LINES_H_SYNC_START  (-30)   // hsync first sx, inside blanking
`define LINES_H_SYNC_END    (-20)   // hsync ends before this sx

`define LINES_V_ACTIVE      48      // active lines per frame
`define LINES_V_BLANK       6       // blanking lines per frame
`define LINES_V_SYNC_START  (-4)    // vsync first sy
`define LINES_V_SYNC_END    (-2)    // vsync ends before this sy

// framebuffer geometry
`define LINES_FB_WIDTH      32
`define LINES_FB_HEIGHT     24
`define LINES_FB_SCALE      2       // power of two, pixel and row repeat

// widths
`define LINES_CORDW         16      // signed screen and draw coordinates
`define LINES_CIDXW         2       // colour index
`define LINES_CHANW         4       // one rgb channel

// fixed palette, 12-bit rgb
`define LINES_PAL_0         12'h000 // black background
`define LINES_PAL_1         12'hF30
`define LINES_PAL_2         12'h3F4
`define LINES_PAL_3         12'h4AF

`endif

//--- lines_pkg.sv
/* line drawing subsystem types
   width typedefs, command and raster structs, renderer state */

`include "lines_defs.svh"

package lines_pkg;

    // widths with a meaning
    typedef logic signed [`LINES_CORDW-1:0] coord_t;
    typedef logic [`LINES_CIDXW-1:0] cidx_t;
    typedef logic [$clog2(`LINES_FB_WIDTH*`LINES_FB_HEIGHT)-1:0] fb_addr_t;
    typedef logic [`LINES_CHANW-1:0] chan_t;
    typedef logic [3*`LINES_CHANW-1:0] colr_t;  // r, g, b from msb down

    typedef enum logic [0:0] {
        cmd_clear = 1'b0,   // fill whole bitmap
        cmd_line  = 1'b1    // bresenham line x0,y0 to x1,y1
    } cmd_kind_t;

    // host command, valid for the strobe cycle only
    typedef struct packed {
        cmd_kind_t kind;
        coord_t    x0;
        coord_t    y0;
        coord_t    x1;
        coord_t    y1;
        cidx_t     cidx;
    } line_cmd_t;

    // one pixel from the renderer
    typedef struct packed {
        logic   valid;
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } draw_pix_t;

    // one raster position with its sync
    typedef struct packed {
        coord_t sx;     // negative in horizontal blanking
        coord_t sy;     // negative in vertical blanking
        logic   hsync;
        logic   vsync;
        logic   de;
        logic   line;   // first blanking pixel of a line
        logic   frame;  // first pixel of a frame
    } raster_t;

    typedef enum logic [2:0] {
        st_idle,
        st_clear,
        st_line_init,
        st_line_draw,
        st_finish
    } render_state_t;

endpackage

//--- lines_stimulus.txt
# C cidx | L x0 y0 x1 y1 cidx | I same as L, strobed while the next line is busy
# K x y rgb12 framebuffer pixel check | F capture a frame and run pending checks
C 3
K 0 0 4AF
K 31 23 4AF
F
C 0
L 2 3 9 3 1
K 2 3 F30
K 9 3 F30
K 10 3 000
L 20 22 20 16 2
K 20 16 3F4
K 20 15 000
L 10 8 14 10 3
K 11 9 4AF
K 12 9 4AF
K 12 10 000
L 30 0 25 5 2
K 27 3 3F4
K 28 3 000
L -3 12 4 12 1
K 0 12 F30
K 4 12 F30
K 31 11 000
L 29 5 34 5 3
K 31 5 4AF
K 0 6 000
I 0 20 8 20 2
L 5 1 5 9 3
K 5 3 4AF
K 4 20 000
F

//--- lines_top.f
+incdir+.
lines_pkg.sv
display_timing.sv
render_line.sv
bitmap_addr.sv
framebuffer_sdp.sv
scanout_linebuffer.sv
clut_paint.sv
lines_top.sv
lines_top_sva.sv
tb_lines_top.sv

//--- lines_top.sv
/* line drawing top level
   draw pipeline into the framebuffer and scaled scan-out to video */

`timescale 1ns/1ps
`include "lines_defs.svh"

module lines_top (
    input  logic                 clk_sys,
    input  logic                 rst_sys,
    input  logic                 cmd_valid,
    input  lines_pkg::line_cmd_t cmd,
    output logic                 busy,
    output logic                 done,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 de,
    output lines_pkg::chan_t     red,
    output lines_pkg::chan_t     green,
    output lines_pkg::chan_t     blue
);

    // draw path
    lines_pkg::draw_pix_t draw_pix;
    logic                 fb_we;
    lines_pkg::fb_addr_t  fb_addr_write;
    lines_pkg::cidx_t     fb_cidx_write;

    // scan-out path
    lines_pkg::raster_t   raster;
    lines_pkg::raster_t   raster_lb;     // one cycle behind raster
    lines_pkg::fb_addr_t  fb_addr_read;
    lines_pkg::cidx_t     fb_cidx_read;
    lines_pkg::cidx_t     lb_cidx;

    render_line i_render_line (
        .clk_sys, .rst_sys, .cmd_valid, .cmd,
        .pix(draw_pix), .busy, .done
    );

    bitmap_addr i_bitmap_addr (
        .clk_sys, .rst_sys, .pix(draw_pix),
        .we(fb_we), .addr(fb_addr_write), .cidx(fb_cidx_write)
    );

    framebuffer_sdp i_framebuffer_sdp (
        .clk_sys, .we(fb_we), .addr_write(fb_addr_write), .data_in(fb_cidx_write),
        .addr_read(fb_addr_read), .data_out(fb_cidx_read)
    );

    display_timing i_display_timing (.clk_sys, .rst_sys, .pos(raster));

    scanout_linebuffer i_scanout_linebuffer (
        .clk_sys, .rst_sys, .pos(raster),
        .fb_addr(fb_addr_read), .fb_data(fb_cidx_read),
        .pix_cidx(lb_cidx), .pos_out(raster_lb)
    );

    clut_paint i_clut_paint (
        .clk_sys, .rst_sys, .cidx(lb_cidx), .pos(raster_lb),
        .hsync, .vsync, .de, .red, .green, .blue
    );

endmodule

//--- lines_top_sva.sv
/* bound assertions on the line drawing top level
   renderer done and busy, blanking colour, sync placement */

`timescale 1ns/1ps
`include "lines_defs.svh"

module lines_top_sva (
    input logic             clk_sys,
    input logic             rst_sys,
    input logic             busy,
    input logic             done,
    input logic             hsync,
    input logic             vsync,
    input logic             de,
    input lines_pkg::chan_t red,
    input lines_pkg::chan_t green,
    input lines_pkg::chan_t blue
);

    done_pulse: assert property (@(posedge clk_sys) disable iff (rst_sys) done |=> !done)
        else $error("done held high for more than one cycle");

    // busy drops in the same cycle as done
    done_busy_fall: assert property (@(posedge clk_sys) disable iff (rst_sys)
        done |-> !busy && $past(busy))
        else $error("done without busy falling");

    blank_black: assert property (@(posedge clk_sys) disable iff (rst_sys)
        !de |-> (red == '0) && (green == '0) && (blue == '0))
        else $error("colour outside the active area");

    sync_in_blank: assert property (@(posedge clk_sys) de |-> !hsync && !vsync)
        else $error("sync high during active video");

    reset_idle: assert property (@(posedge clk_sys) rst_sys |=> !busy && !done)
        else $error("renderer not idle after reset");

endmodule

bind lines_top lines_top_sva i_lines_top_sva (.*);

//--- render_line.sv
/* line renderer
   clear and integer bresenham line commands, one pixel per cycle */

`timescale 1ns/1ps
`include "lines_defs.svh"

module render_line (
    input  logic                 clk_sys,
    input  logic                 rst_sys,
    input  logic                 cmd_valid,
    input  lines_pkg::line_cmd_t cmd,
    output lines_pkg::draw_pix_t pix,
    output logic                 busy,
    output logic                 done
);

    lines_pkg::render_state_t state;

    lines_pkg::coord_t x, y;        // current pixel
    lines_pkg::coord_t xe, ye;      // line endpoint
    lines_pkg::cidx_t  colr;
    logic x_inc, y_inc;             // step directions
    logic signed [`LINES_CORDW:0]   dx, dy;   // dx >= 0, dy <= 0
    logic signed [`LINES_CORDW+1:0] err;
    logic signed [`LINES_CORDW+2:0] e2;
    logic signed [`LINES_CORDW:0]   adx, ady; // abs deltas, init only
    logic signed [`LINES_CORDW+1:0] err_step;
    logic accept;

    // accepted in idle and in finish since busy is already low there
    assign accept = cmd_valid && !busy;
    assign busy   = (state == lines_pkg::st_clear) || (state == lines_pkg::st_line_init)
                 || (state == lines_pkg::st_line_draw);
    assign done   = (state == lines_pkg::st_finish);

    always_comb begin
        adx = (xe > x) ? xe - x : x - xe;
        ady = (ye > y) ? ye - y : y - ye;
        e2  = err <<< 1;
        err_step = '0;
        if (e2 >= dy) err_step = err_step + dy;    // x step
        if (e2 <= dx) err_step = err_step + dx;    // y step
    end

    // pixel out straight from the state registers
    always_comb begin
        pix.valid = (state == lines_pkg::st_clear) || (state == lines_pkg::st_line_draw);
        pix.x     = x;
        pix.y     = y;
        pix.cidx  = colr;
    end

    always_ff @(posedge clk_sys) begin
        case (state)
            lines_pkg::st_clear: begin
                if (x == lines_pkg::coord_t'(`LINES_FB_WIDTH - 1)) begin
                    x <= '0;
                    if (y == lines_pkg::coord_t'(`LINES_FB_HEIGHT - 1)) state <= lines_pkg::st_finish;
                    else y <= lines_pkg::coord_t'(y + 1);
                end else begin
                    x <= lines_pkg::coord_t'(x + 1);
                end
            end
            lines_pkg::st_line_init: begin
                dx    <= adx;
                dy    <= -ady;
                err   <= adx - ady;
                x_inc <= (xe > x);
                y_inc <= (ye > y);
                state <= lines_pkg::st_line_draw;
            end
            lines_pkg::st_line_draw: begin
                if (x == xe && y == ye) begin
                    state <= lines_pkg::st_finish;  // endpoint emitted this cycle
                end else begin
                    if (e2 >= dy) x <= x_inc ? lines_pkg::coord_t'(x + 1) : lines_pkg::coord_t'(x - 1);
                    if (e2 <= dx) y <= y_inc ? lines_pkg::coord_t'(y + 1) : lines_pkg::coord_t'(y - 1);
                    err <= err + err_step;
                end
            end
            default: begin  // idle, finish
                if (accept) begin
                    colr <= cmd.cidx;
                    if (cmd.kind == lines_pkg::cmd_clear) begin
                        x     <= '0;
                        y     <= '0;
                        state <= lines_pkg::st_clear;
                    end else begin
                        x     <= cmd.x0;
                        y     <= cmd.y0;
                        xe    <= cmd.x1;
                        ye    <= cmd.y1;
                        state <= lines_pkg::st_line_init;
                    end
                end else begin
                    state <= lines_pkg::st_idle;
                end
            end
        endcase
        if (rst_sys) state <= lines_pkg::st_idle;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the lines_top testbench with verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim_lines_top.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lines_top -f lines_top.f -Mdir obj_dir -o sim_lines_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_lines_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0

//--- scanout_linebuffer.sv
/* scan-out line buffer
   fetches one framebuffer row during blanking and replays it scaled in x and y */

`timescale 1ns/1ps
`include "lines_defs.svh"

module scanout_linebuffer (
    input  logic                clk_sys,
    input  logic                rst_sys,
    input  lines_pkg::raster_t  pos,
    output lines_pkg::fb_addr_t fb_addr,
    input  lines_pkg::cidx_t    fb_data,
    output lines_pkg::cidx_t    pix_cidx,
    output lines_pkg::raster_t  pos_out
);

    localparam int LB_SHIFT = $clog2(`LINES_FB_SCALE);  // scale is a power of two
    localparam int LB_IDXW  = $clog2(`LINES_FB_WIDTH);

    lines_pkg::cidx_t    lb [`LINES_FB_WIDTH];   // line buffer
    lines_pkg::fb_addr_t fetch_base;             // first address of the row
    logic [LB_IDXW-1:0]  fetch_cnt;
    logic                fetching;
    logic                wr_en;                  // read data arrives a cycle late
    logic [LB_IDXW-1:0]  wr_idx;
    logic [LB_IDXW-1:0]  rd_idx;
    logic                fetch_line;

    // first line of each scale group, other lines reuse the buffer
    assign fetch_line = pos.line && (pos.sy >= 0)
                     && ((pos.sy & lines_pkg::coord_t'(`LINES_FB_SCALE - 1)) == 0);

    assign fb_addr = fetch_base + lines_pkg::fb_addr_t'(fetch_cnt);

    // fetch counter, one read per cycle
    always_ff @(posedge clk_sys) begin
        if (fetch_line) begin
            fetching   <= 1'b1;
            fetch_cnt  <= '0;
            fetch_base <= lines_pkg::fb_addr_t'(pos.sy >>> LB_SHIFT)
                        * lines_pkg::fb_addr_t'(`LINES_FB_WIDTH);
        end else if (fetching) begin
            fetch_cnt <= fetch_cnt + 1'b1;
            if (fetch_cnt == LB_IDXW'(`LINES_FB_WIDTH - 1)) fetching <= 1'b0;  // last read
        end
        if (rst_sys) fetching <= 1'b0;
    end

    // align buffer write with read latency
    always_ff @(posedge clk_sys) begin
        wr_en  <= fetching;
        wr_idx <= fetch_cnt;
        if (rst_sys) wr_en <= 1'b0;
    end

    always_ff @(posedge clk_sys) begin
        if (wr_en) lb[wr_idx] <= fb_data;
    end

    // sx divided by scale picks the entry
    assign rd_idx = pos.sx[LB_SHIFT +: LB_IDXW];

    always_ff @(posedge clk_sys) begin
        pix_cidx <= lb[rd_idx];
        pos_out  <= pos;        // one cycle, alongside the index
        if (rst_sys) begin
            pos_out.hsync <= 1'b0;
            pos_out.vsync <= 1'b0;
            pos_out.de    <= 1'b0;
            pos_out.line  <= 1'b0;
            pos_out.frame <= 1'b0;
        end
    end

endmodule

//--- tb_lines_top.sv
/* testbench for the line drawing subsystem
   runs commands from the stimulus file and checks the scaled raster */

`timescale 1ns/1ps
`include "lines_defs.svh"

module tb_lines_top;

    localparam int FB_PIXELS  = `LINES_FB_WIDTH * `LINES_FB_HEIGHT;
    localparam int SCALE      = `LINES_FB_SCALE;
    localparam int FRAME_COLS = `LINES_FB_WIDTH * `LINES_FB_SCALE;
    localparam int FRAME_ROWS = `LINES_FB_HEIGHT * `LINES_FB_SCALE;
    localparam int FRAME_CLKS = (`LINES_H_ACTIVE + `LINES_H_BLANK)
                              * (`LINES_V_ACTIVE + `LINES_V_BLANK);
    localparam int CW         = `LINES_CHANW;
    localparam int HS_FIRST   = `LINES_H_SYNC_START + `LINES_H_BLANK;  // blank pixels before hsync
    localparam int HS_LEN     = `LINES_H_SYNC_END - `LINES_H_SYNC_START;

    typedef struct packed {
        byte                  tag;  // C, L, I, K or F
        lines_pkg::line_cmd_t cmd;  // K keeps its pixel in x0, y0
        lines_pkg::colr_t     exp;
    } rec_t;

    logic                 clk_sys;
    logic                 rst_sys;
    logic                 cmd_valid;
    lines_pkg::line_cmd_t cmd;
    logic                 busy;
    logic                 done;
    logic                 hsync;
    logic                 vsync;
    logic                 de;
    lines_pkg::chan_t     red;
    lines_pkg::chan_t     green;
    lines_pkg::chan_t     blue;

    rec_t                 recs[$];
    rec_t                 checks[$];    // pending until next capture
    lines_pkg::line_cmd_t ign_cmd;
    logic                 ign_pending;
    lines_pkg::colr_t     disp [FRAME_ROWS][FRAME_COLS];
    integer               seed = 32'h95ad_8287;
    int                   gap;
    int                   wd_cycles = 0;

    lines_top i_lines_top (.*);

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    // watchdog, armed once the stimulus length is known
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk_sys);
        stop_run("watchdog timeout, the run took far longer than the tests need");
    end

    task stop_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task check_done(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("Fail at %0t ns: %s, got %b expected %b", $time, what, got, exp));
        end
    endtask

    task check_colr(input lines_pkg::chan_t r, input lines_pkg::chan_t g,
                    input lines_pkg::chan_t b, input lines_pkg::chan_t er,
                    input lines_pkg::chan_t eg, input lines_pkg::chan_t eb,
                    input string what);
        if ({r, g, b} !== {er, eg, eb}) begin
            stop_run($sformatf("Fail at %0t ns: %s, got %h%h%h expected %h%h%h",
                               $time, what, r, g, b, er, eg, eb));
        end
    endtask

    task read_stimulus;
        int    fd;
        int    a, b, c, d, e;
        int    steps;
        string line;
        rec_t  r;
        steps = 0;
        fd = $fopen("lines_stimulus.txt", "r");
        if (fd == 0) stop_run("could not open lines_stimulus.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;     // comments, blank lines
            r = '0;
            r.tag = line[0];
            if (r.tag == "K") begin
                void'($sscanf(line.substr(1, line.len() - 1), "%d %d %h", a, b, e));
                r.cmd.x0 = lines_pkg::coord_t'(a);
                r.cmd.y0 = lines_pkg::coord_t'(b);
                r.exp    = lines_pkg::colr_t'(e);
            end else begin
                void'($sscanf(line.substr(1, line.len() - 1), "%d %d %d %d %d",
                              a, b, c, d, e));
                r.cmd.kind = (r.tag == "C") ? lines_pkg::cmd_clear : lines_pkg::cmd_line;
                r.cmd.x0   = lines_pkg::coord_t'(a);
                r.cmd.y0   = lines_pkg::coord_t'(b);
                r.cmd.x1   = lines_pkg::coord_t'(c);
                r.cmd.y1   = lines_pkg::coord_t'(d);
                r.cmd.cidx = lines_pkg::cidx_t'((r.tag == "C") ? a : e);
                steps++;
            end
            recs.push_back(r);
        end
        $fclose(fd);
        wd_cycles = (steps * FRAME_CLKS + FB_PIXELS + 1) * 3;
    endtask

    // strobe one command, optionally a second one while busy, then wait for done
    task run_cmd(input lines_pkg::line_cmd_t c);
        int cnt;
        @(posedge clk_sys);
        #1;
        cmd       = c;
        cmd_valid = 1'b1;
        @(posedge clk_sys);     // accepted here
        #1;
        cmd_valid = 1'b0;
        if (ign_pending && c.kind == lines_pkg::cmd_line) begin
            cmd         = ign_cmd;  // renderer busy, must be dropped
            cmd_valid   = 1'b1;
            ign_pending = 1'b0;
        end
        @(negedge clk_sys);
        check_done(busy, 1'b1, "busy after accept");
        cnt = 1;
        @(posedge clk_sys);
        #1;
        cmd_valid = 1'b0;
        if (c.kind == lines_pkg::cmd_clear) begin
            // done lands exactly one cycle after the last pixel
            repeat (FB_PIXELS - 1) begin
                @(negedge clk_sys);
                check_done(done, 1'b0, "done before the clear finished");
            end
            @(negedge clk_sys);
            check_done(done, 1'b1, "done at width times height plus 1 after a clear");
        end else begin
            while (!done) begin
                @(negedge clk_sys);
                cnt++;
                if (cnt > 4 * FB_PIXELS) stop_run("line command never raised done");
            end
        end
        check_done(busy, 1'b0, "busy in the done cycle");
        @(negedge clk_sys);
        check_done(done, 1'b0, "extra done after a command");
        check_done(busy, 1'b0, "command strobed while busy was accepted");
    endtask

    // rows and columns counted from de runs after the end of vsync
    task capture_frame;
        int col;
        int blank;
        int hs_first;
        int hs_len;
        while (vsync) @(negedge clk_sys);
        while (!vsync) @(negedge clk_sys);
        while (vsync) @(negedge clk_sys);
        for (int row = 0; row < FRAME_ROWS; row++) begin
            blank    = 0;
            hs_first = -1;
            hs_len   = 0;
            while (!de) begin
                if (hsync) begin
                    if (hs_len == 0) hs_first = blank;
                    hs_len++;
                end
                blank++;
                @(negedge clk_sys);
            end
            // one hsync pulse in the blanking between two active rows
            if (row > 0 && (hs_first != HS_FIRST || hs_len != HS_LEN)) begin
                stop_run($sformatf("Fail at %0t ns: hsync before row %0d at %0d for %0d, %s %0d for %0d",
                                   $time, row, hs_first, hs_len, "expected", HS_FIRST, HS_LEN));
            end
            col = 0;
            while (de) begin
                if (col < FRAME_COLS) disp[row][col] = {red, green, blue};
                col++;
                @(negedge clk_sys);
            end
            if (col != FRAME_COLS) begin
                stop_run($sformatf("Fail at %0t ns: display row %0d has %0d active pixels",
                                   $time, row, col));
            end
        end
        while (!vsync) begin
            if (de) stop_run("active pixels below the last framebuffer row");
            @(negedge clk_sys);
        end
    endtask

    // each framebuffer pixel is a scale by scale block
    task compare_checks;
        int               x;
        int               y;
        lines_pkg::colr_t got;
        lines_pkg::colr_t exp;
        foreach (checks[i]) begin
            x   = int'(checks[i].cmd.x0);
            y   = int'(checks[i].cmd.y0);
            exp = checks[i].exp;
            for (int dy = 0; dy < SCALE; dy++) begin
                for (int dx = 0; dx < SCALE; dx++) begin
                    got = disp[y * SCALE + dy][x * SCALE + dx];
                    check_colr(got[3*CW-1 -: CW], got[2*CW-1 -: CW], got[CW-1:0],
                               exp[3*CW-1 -: CW], exp[2*CW-1 -: CW], exp[CW-1:0],
                               $sformatf("pixel %0d,%0d block %0d,%0d", x, y, dx, dy));
                end
            end
        end
    endtask

    initial begin
        rst_sys     = 1'b1;
        cmd_valid   = 1'b0;
        cmd         = '0;
        ign_cmd     = '0;
        ign_pending = 1'b0;
        read_stimulus();
        repeat (3) @(posedge clk_sys);
        #1;
        rst_sys = 1'b0;
        @(negedge clk_sys);
        check_done(busy, 1'b0, "busy after reset");
        check_done(done, 1'b0, "done after reset");
        check_done(hsync, 1'b0, "hsync after reset");
        check_done(vsync, 1'b0, "vsync after reset");
        check_done(de, 1'b0, "de after reset");
        check_colr(red, green, blue, '0, '0, '0, "colour after reset");
        foreach (recs[i]) begin
            case (recs[i].tag)
                "C", "L": begin
                    gap = $random(seed) & 7;    // idle gap between commands
                    repeat (gap) @(posedge clk_sys);
                    run_cmd(recs[i].cmd);
                end
                "I": begin
                    ign_cmd     = recs[i].cmd;
                    ign_pending = 1'b1;
                end
                "K": checks.push_back(recs[i]);
                "F": begin
                    capture_frame();
                    compare_checks();
                    checks.delete();
                end
                default: stop_run("unknown record in lines_stimulus.txt");
            endcase
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule
